/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = claAluTb
FILELIST  = claAlu.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
FAILMSG   = Errors found
SOURCES   = $(wildcard source/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* claAlu.f */
+incdir+testbench
source/claPkg.sv
source/aluPkg.sv
source/claGroup4.sv
source/claBlock16.sv
source/claAdder32.sv
source/aluCore.sv
source/claAlu.sv
testbench/claAluTb.sv

/* source/aluCore.sv */
`timescale 1ns/1ps

module aluCore import aluPkg::*; (
  input  aluRequest request,
  output aluResult  result
);

  logic                 invertB;       // subtract path.
  logic                 adderCarryIn;
  logic [dataWidth-1:0] adderB;
  logic [dataWidth-1:0] adderSum;
  logic                 adderCarryOut;
  logic                 adderOverflow;
  logic                 signedLess;
  logic                 unsignedLess;
  logic                 isLogic;       // carry and overflow forced low.
  logic [dataWidth-1:0] value;

  // ******************************
  // adder operand preparation
  // ******************************

  always_comb begin
    invertB      = 1'b0;
    adderCarryIn = 1'b0;
    case (request.op)
      opAddCarry: begin
        adderCarryIn = request.carryIn;
      end
      opSub, opLessSigned, opLessUnsigned: begin
        invertB      = 1'b1;
        adderCarryIn = 1'b1;
      end
      opSubBorrow: begin
        invertB      = 1'b1;
        adderCarryIn = ~request.carryIn; // borrow clears the +1.
      end
      default: begin
        invertB      = 1'b0;
        adderCarryIn = 1'b0;
      end
    endcase
  end

  assign adderB = invertB ? ~request.operandB : request.operandB;

  claAdder32 adder_inst (
    .a        (request.operandA),
    .b        (adderB),
    .carryIn  (adderCarryIn),
    .sum      (adderSum),
    .carryOut (adderCarryOut),
    .overflow (adderOverflow)
  );

  assign signedLess   = adderSum[dataWidth-1] ^ adderOverflow;
  assign unsignedLess = ~adderCarryOut; // borrow out of a - b.

  // ******************************
  // result select
  // ******************************

  always_comb begin
    value   = adderSum;
    isLogic = 1'b0;
    case (request.op)
      opLessSigned:   value = {{(dataWidth-1){1'b0}}, signedLess};
      opLessUnsigned: value = {{(dataWidth-1){1'b0}}, unsignedLess};
      opAnd: begin
        value   = request.operandA & request.operandB;
        isLogic = 1'b1;
      end
      opOr: begin
        value   = request.operandA | request.operandB;
        isLogic = 1'b1;
      end
      opXor: begin
        value   = request.operandA ^ request.operandB;
        isLogic = 1'b1;
      end
      default: begin
        value   = adderSum;
        isLogic = 1'b0;
      end
    endcase
  end

  assign result.value          = value;
  assign result.flags.carry    = isLogic ? 1'b0 : adderCarryOut;
  assign result.flags.overflow = isLogic ? 1'b0 : adderOverflow;
  assign result.flags.zero     = (value == '0);
  assign result.flags.negative = value[dataWidth-1];

endmodule

/* source/aluPkg.sv */
package aluPkg;

  localparam int dataWidth = 32; // operand and result width.

  // ******************************
  // opcodes
  // ******************************

  typedef enum logic [3:0] {
    opAdd          = 4'd0,
    opAddCarry     = 4'd1,
    opSub          = 4'd2,
    opSubBorrow    = 4'd3, // carryIn acts as borrow.
    opLessSigned   = 4'd4,
    opLessUnsigned = 4'd5,
    opAnd          = 4'd6,
    opOr           = 4'd7,
    opXor          = 4'd8
  } aluOp;

  // ******************************
  // request and result
  // ******************************

  typedef struct packed {
    logic carry;    // adder carry out, 1 means no borrow on subtract.
    logic overflow; // signed overflow of the adder.
    logic zero;
    logic negative;
  } aluFlags;

  typedef struct packed {
    aluOp                 op;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic                 carryIn;
  } aluRequest;

  typedef struct packed {
    logic [dataWidth-1:0] value;
    aluFlags              flags;
  } aluResult;

endpackage

/* source/claAdder32.sv */
`timescale 1ns/1ps

module claAdder32 import claPkg::*; (
  input  logic [claWidth-1:0] a,
  input  logic [claWidth-1:0] b,
  input  logic                carryIn,
  output logic [claWidth-1:0] sum,
  output logic                carryOut,
  output logic                overflow
);

  pgPair [blockCount-1:0] blockPg;
  logic                   upperCarry; // carry into bit 16.

  claBlock16 lowerBlock_inst (
    .a       (a[blockWidth-1:0]),
    .b       (b[blockWidth-1:0]),
    .carryIn (carryIn),
    .sum     (sum[blockWidth-1:0]),
    .blockPg (blockPg[0])
  );

  claBlock16 upperBlock_inst (
    .a       (a[claWidth-1:blockWidth]),
    .b       (b[claWidth-1:blockWidth]),
    .carryIn (upperCarry),
    .sum     (sum[claWidth-1:blockWidth]),
    .blockPg (blockPg[1])
  );

  assign upperCarry = blockPg[0].gen | (blockPg[0].prop & carryIn);
  assign carryOut   = blockPg[1].gen
                    | (blockPg[1].prop & blockPg[0].gen)
                    | (blockPg[1].prop & blockPg[0].prop & carryIn);

  // like signs in, other sign out.
  assign overflow = (a[claWidth-1] == b[claWidth-1]) && (sum[claWidth-1] != a[claWidth-1]);

endmodule

/* source/claAlu.sv */
`timescale 1ns/1ps

module claAlu import aluPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      inStrobe,
  input  aluRequest request,
  output logic      outStrobe,
  output aluResult  result
);

  aluRequest requestReg;
  logic      requestValid;
  aluResult  coreResult;

  // ******************************
  // pipeline control
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      requestValid <= 1'b0;
      outStrobe    <= 1'b0;
    end else begin
      requestValid <= inStrobe;
      outStrobe    <= requestValid; // result valid one edge after capture.
    end
  end

  // payload registers.
  always_ff @(posedge clk) begin
    if (inStrobe) begin
      requestReg <= request;
    end
    if (requestValid) begin
      result <= coreResult;
    end
  end

  aluCore core_inst (
    .request (requestReg),
    .result  (coreResult)
  );

  // ******************************
  // assertions
  // ******************************

  // every accepted request shows up exactly two edges later, and nothing else does.
  assert property (@(posedge clk) disable iff (reset)
    inStrobe |-> ##2 outStrobe);

  assert property (@(posedge clk) disable iff (reset)
    outStrobe |-> $past(inStrobe, 2));

  // comparisons land as a single bit in the result register.
  assert property (@(posedge clk) disable iff (reset)
    requestValid && (requestReg.op inside {opLessSigned, opLessUnsigned})
      |=> (result.value <= dataWidth'(1)));

  assert property (@(posedge clk) disable iff (reset)
    outStrobe |-> (result.flags.zero == (result.value == '0)));

endmodule

/* source/claBlock16.sv */
`timescale 1ns/1ps

module claBlock16 import claPkg::*; (
  input  logic [blockWidth-1:0] a,
  input  logic [blockWidth-1:0] b,
  input  logic                  carryIn,
  output logic [blockWidth-1:0] sum,
  output pgPair                 blockPg
);

  pgPair [groupCount-1:0] groupPg;
  logic  [groupCount-1:0] gp;         // group propagate.
  logic  [groupCount-1:0] gg;         // group generate.
  logic  [groupCount-1:0] groupCarry; // carry into each group.

  for (genvar i = 0; i < groupCount; i++) begin : gGroup
    claGroup4 group_inst (
      .a       (a[i*groupWidth +: groupWidth]),
      .b       (b[i*groupWidth +: groupWidth]),
      .carryIn (groupCarry[i]),
      .sum     (sum[i*groupWidth +: groupWidth]),
      .groupPg (groupPg[i])
    );
    assign gp[i] = groupPg[i].prop;
    assign gg[i] = groupPg[i].gen;
  end

  // ******************************
  // second-level lookahead
  // ******************************

  // all group carries come straight from carryIn, no ripple between groups.
  assign groupCarry[0] = carryIn;
  assign groupCarry[1] = gg[0] | (gp[0] & carryIn);
  assign groupCarry[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & carryIn);
  assign groupCarry[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                       | (gp[2] & gp[1] & gp[0] & carryIn);

  assign blockPg.prop = &gp;
  assign blockPg.gen  = gg[3]
                      | (gp[3] & gg[2])
                      | (gp[3] & gp[2] & gg[1])
                      | (gp[3] & gp[2] & gp[1] & gg[0]);

endmodule

/* source/claGroup4.sv */
`timescale 1ns/1ps

module claGroup4 import claPkg::*; (
  input  logic [groupWidth-1:0] a,
  input  logic [groupWidth-1:0] b,
  input  logic                  carryIn,
  output logic [groupWidth-1:0] sum,
  output pgPair                 groupPg
);

  logic [groupWidth-1:0] p;     // bit propagate.
  logic [groupWidth-1:0] g;     // bit generate.
  logic [groupWidth-1:0] carry; // carry into each bit.

  assign p = a ^ b;
  assign g = a & b;

  // ******************************
  // lookahead carries
  // ******************************

  assign carry[0] = carryIn;
  assign carry[1] = g[0] | (p[0] & carryIn);
  assign carry[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carryIn);
  assign carry[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                  | (p[2] & p[1] & p[0] & carryIn);

  assign sum = p ^ carry;

  // group terms for the block level.
  assign groupPg.prop = &p;
  assign groupPg.gen  = g[3]
                      | (p[3] & g[2])
                      | (p[3] & p[2] & g[1])
                      | (p[3] & p[2] & p[1] & g[0]);

endmodule

/* source/claPkg.sv */
package claPkg;

  // ******************************
  // adder geometry
  // ******************************

  localparam int claWidth   = 32; // full adder width.
  localparam int groupWidth = 4;  // bits per first-level lookahead group.
  localparam int blockWidth = 16; // bits per second-level lookahead block.

  // groups per block and blocks per adder.
  localparam int groupCount = blockWidth / groupWidth;
  localparam int blockCount = claWidth / blockWidth;

  // ******************************
  // lookahead terms
  // ******************************

  // propagate and generate of a group or a block, seen from the next level up.
  typedef struct packed {
    logic prop; // carry in passes through.
    logic gen;  // carry out produced regardless of carry in.
  } pgPair;

endpackage

/* testbench/aluModel.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// ******************************
// reference model
// ******************************

// expected result of one request, from the arithmetic meaning of each opcode.
function automatic aluResult predictResult(input aluRequest req);
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic [dataWidth:0]   wide;   // extra bit holds carry or borrow.
  logic                 carryIn;
  logic                 borrow;
  logic [dataWidth-1:0] diff;
  aluResult             res;

  a   = req.operandA;
  b   = req.operandB;
  res = '0;
  case (req.op)
    opAdd, opAddCarry: begin
      carryIn            = (req.op == opAddCarry) ? req.carryIn : 1'b0;
      wide               = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, carryIn};
      res.value          = wide[dataWidth-1:0];
      res.flags.carry    = wide[dataWidth];
      res.flags.overflow = (a[dataWidth-1] == b[dataWidth-1])
                           && (res.value[dataWidth-1] != a[dataWidth-1]);
    end
    opSub, opSubBorrow, opLessSigned, opLessUnsigned: begin
      borrow             = (req.op == opSubBorrow) ? req.carryIn : 1'b0;
      wide               = {1'b0, a} - {1'b0, b} - {{dataWidth{1'b0}}, borrow};
      diff               = wide[dataWidth-1:0];
      res.flags.carry    = ~wide[dataWidth]; // set when a - b - borrow stays non-negative.
      res.flags.overflow = (a[dataWidth-1] != b[dataWidth-1])
                           && (diff[dataWidth-1] != a[dataWidth-1]);
      if (req.op == opLessSigned) begin
        res.value = {{(dataWidth-1){1'b0}}, ($signed(a) < $signed(b))};
      end else if (req.op == opLessUnsigned) begin
        res.value = {{(dataWidth-1){1'b0}}, (a < b)};
      end else begin
        res.value = diff;
      end
    end
    opAnd: begin
      res.value = a & b;
    end
    opOr: begin
      res.value = a | b;
    end
    opXor: begin
      res.value = a ^ b;
    end
    default: begin
      res.value = '0;
    end
  endcase

  res.flags.zero     = (res.value == '0);
  res.flags.negative = res.value[dataWidth-1];
  return res;
endfunction

`endif

/* testbench/claAluTb.sv */
`timescale 1ns/1ps

module claAluTb import aluPkg::*;;

  `include "aluModel.svh"

  localparam int resetCycles    = 16;
  localparam int directedCount  = 8;
  localparam int stimulusCycles = 2000;
  localparam int drainCycles    = 4;
  localparam int cycleLimit     = resetCycles + directedCount + stimulusCycles + 100;

  logic      clk = 1'b0;
  logic      reset;
  logic      inStrobe;
  aluRequest request;
  logic      outStrobe;
  aluResult  result;

  aluResult    expectedQ[$];
  aluOp        opQ[$];
  int          dueQ[$];             // cycle in which each result is due.
  int          cycleCount     = 0;
  int          valueErrors    = 0;
  int          flagErrors     = 0;
  int          protocolErrors = 0;

  claAlu claAlu_inst (
    .clk       (clk),
    .reset     (reset),
    .inStrobe  (inStrobe),
    .request   (request),
    .outStrobe (outStrobe),
    .result    (result)
  );

  initial begin
    forever begin
      #20 clk = ~clk;
    end
  end

  // ******************************
  // stimulus
  // ******************************

  function automatic logic [dataWidth-1:0] randomOperand();
    logic [dataWidth-1:0] operand;
    case ($urandom_range(9))
      0:       operand = '0;
      1:       operand = '1;
      2:       operand = 32'h8000_0000;
      3:       operand = 32'h7fff_ffff;
      default: operand = $urandom();
    endcase
    return operand;
  endfunction

  function automatic aluRequest randomRequest();
    aluRequest req;
    req.op       = aluOp'(4'($urandom_range(8)));
    req.operandA = randomOperand();
    req.operandB = randomOperand();
    req.carryIn  = 1'($urandom_range(1));
    return req;
  endfunction

  task automatic sendRequest(input aluRequest req);
    @(posedge clk);
    #2;
    inStrobe = 1'b1;
    request  = req;
    expectedQ.push_back(predictResult(req));
    opQ.push_back(req.op);
    dueQ.push_back(cycleCount + 2); // captured next edge, registered the edge after.
  endtask

  task automatic sendOp(input aluOp op, input logic [dataWidth-1:0] a,
                        input logic [dataWidth-1:0] b, input logic carryIn);
    aluRequest req;
    req.op       = op;
    req.operandA = a;
    req.operandB = b;
    req.carryIn  = carryIn;
    sendRequest(req);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #2;
    inStrobe = 1'b0;
  endtask

  // ******************************
  // checking
  // ******************************

  task automatic checkValue(input aluOp op, input logic [dataWidth-1:0] got,
                            input logic [dataWidth-1:0] expected);
    if (got !== expected) begin
      valueErrors++;
      $display("Mismatch result.value: got %h, expected %h, op %s at %0t",
               got, expected, op.name(), $time);
    end
  endtask

  task automatic checkFlags(input aluOp op, input aluFlags got, input aluFlags expected);
    if (got !== expected) begin
      flagErrors++;
      $display("Mismatch result.flags: got %h, expected %h, op %s at %0t",
               got, expected, op.name(), $time);
    end
  endtask

  always @(negedge clk) begin : monitor
    int due;
    if (reset) begin
      if (outStrobe !== 1'b0) begin
        protocolErrors++;
        $display("outStrobe was not low during reset at %0t", $time);
      end
    end else if (outStrobe === 1'b1) begin
      if (expectedQ.size() == 0) begin
        protocolErrors++;
        $display("outStrobe seen at %0t with no request outstanding", $time);
      end else begin
        due = dueQ.pop_front();
        if (due != cycleCount) begin
          protocolErrors++;
          $display("result arrived in cycle %0d but was due in cycle %0d", cycleCount, due);
        end
        checkValue(opQ[0], result.value, expectedQ[0].value);
        checkFlags(opQ[0], result.flags, expectedQ[0].flags);
        void'(opQ.pop_front());
        void'(expectedQ.pop_front());
      end
    end else if (outStrobe !== 1'b0) begin
      protocolErrors++;
      $display("outStrobe is unknown at %0t", $time);
    end
  end

  // watchdog.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  // ******************************
  // main sequence
  // ******************************

  initial begin
    void'($urandom(32'h1590_b748));
    reset     = 1'b1;
    inStrobe  = 1'b0;
    request   = '0;
    repeat (resetCycles) @(posedge clk);
    #2;
    reset = 1'b0;

    // carries across group and block boundaries, then sign corners.
    sendOp(opAdd,          32'hffff_ffff, 32'h0000_0001, 1'b0);
    sendOp(opAdd,          32'h0000_ffff, 32'h0000_0001, 1'b0);
    sendOp(opAddCarry,     32'h7fff_ffff, 32'h0000_0000, 1'b1);
    sendOp(opSub,          32'h0000_0000, 32'h0000_0001, 1'b0);
    sendOp(opSubBorrow,    32'h0000_0000, 32'h0000_0000, 1'b1);
    sendOp(opLessSigned,   32'h8000_0000, 32'h7fff_ffff, 1'b0);
    sendOp(opLessUnsigned, 32'h8000_0000, 32'h7fff_ffff, 1'b0);
    sendOp(opXor,          32'ha5a5_a5a5, 32'ha5a5_a5a5, 1'b0);

    for (int i = 0; i < stimulusCycles; i++) begin
      if ($urandom_range(99) < 80) begin
        sendRequest(randomRequest());
      end else begin
        idleCycle();
      end
    end
    idleCycle();
    repeat (drainCycles) @(posedge clk);
    @(negedge clk);

    if (expectedQ.size() != 0) begin
      protocolErrors++;
      $display("%0d results never arrived", expectedQ.size());
    end
    $display("value errors %0d, flag errors %0d, protocol errors %0d",
             valueErrors, flagErrors, protocolErrors);
    if (valueErrors + flagErrors + protocolErrors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
